// File: logic/mips_pkg.sv
package mips_pkg;

  localparam int word_w     = 32;                      // Data and address width
  localparam int reg_addr_w = 5;                       // Register index width
  localparam logic [reg_addr_w-1:0] link_reg = 5'd31;  // Return address register for jal and jalr
  localparam logic [word_w-1:0] reset_vector = 32'hBFC0_0000;  // First fetch after reset

  // Major opcodes in bits 31:26
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_jal     = 6'h03;
  localparam logic [5:0] op_beq     = 6'h04;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_slti    = 6'h0A;
  localparam logic [5:0] op_sltiu   = 6'h0B;
  localparam logic [5:0] op_andi    = 6'h0C;
  localparam logic [5:0] op_ori     = 6'h0D;
  localparam logic [5:0] op_xori    = 6'h0E;
  localparam logic [5:0] op_lui     = 6'h0F;
  localparam logic [5:0] op_lb      = 6'h20;
  localparam logic [5:0] op_lh      = 6'h21;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_lbu     = 6'h24;
  localparam logic [5:0] op_lhu     = 6'h25;
  localparam logic [5:0] op_sw      = 6'h2B;

  // Function codes of the special opcode, bits 5:0
  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_srl  = 6'h02;
  localparam logic [5:0] fn_sra  = 6'h03;
  localparam logic [5:0] fn_sllv = 6'h04;
  localparam logic [5:0] fn_srlv = 6'h06;
  localparam logic [5:0] fn_srav = 6'h07;
  localparam logic [5:0] fn_jr   = 6'h08;
  localparam logic [5:0] fn_jalr = 6'h09;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_xor  = 6'h26;
  localparam logic [5:0] fn_nor  = 6'h27;
  localparam logic [5:0] fn_slt  = 6'h2A;
  localparam logic [5:0] fn_sltu = 6'h2B;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt, alu_sltu,
    alu_sll, alu_srl, alu_sra, alu_sllv, alu_srlv, alu_srav, alu_lui
  } alu_op_t;

  // How the loaded word is cut down and extended
  typedef enum logic [2:0] {
    load_word, load_byte, load_byte_u, load_half, load_half_u
  } load_mode_t;

endpackage

// File: logic/mips_alu.sv
`timescale 1ns/100ps

module mips_alu import mips_pkg::*; (
  input  alu_op_t           alu_op,
  input  logic [word_w-1:0] a,       // rs
  input  logic [word_w-1:0] b,       // rt or the immediate
  input  logic [4:0]        shamt,
  output logic [word_w-1:0] result,
  output logic              zero
);

  logic [4:0] var_shift;
  logic       less_signed;
  logic       less_unsigned;

  assign var_shift     = a[4:0];  // Variable shifts take the amount from rs
  assign less_signed   = $signed(a) < $signed(b);
  assign less_unsigned = a < b;

  always_comb begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_nor:  result = ~(a | b);
      alu_slt:  result = {{(word_w-1){1'b0}}, less_signed};
      alu_sltu: result = {{(word_w-1){1'b0}}, less_unsigned};
      alu_sll:  result = b << shamt;
      alu_srl:  result = b >> shamt;
      alu_sra:  result = $signed(b) >>> shamt;  // Arithmetic shift keeps the sign of rt
      alu_sllv: result = b << var_shift;
      alu_srlv: result = b >> var_shift;
      alu_srav: result = $signed(b) >>> var_shift;
      alu_lui:  result = {b[15:0], 16'h0000};
      default:  result = '0;
    endcase
  end

  // Branches compare with alu_sub and look only at this flag
  assign zero = (result == '0);

endmodule

// File: logic/mips_regfile.sv
`timescale 1ns/100ps

module mips_regfile import mips_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  write_en,
  input  logic [reg_addr_w-1:0] read_addr_a,
  input  logic [reg_addr_w-1:0] read_addr_b,
  input  logic [reg_addr_w-1:0] write_addr,
  input  logic [word_w-1:0]     write_data,
  output logic [word_w-1:0]     read_data_a,
  output logic [word_w-1:0]     read_data_b,
  output logic [word_w-1:0]     register_v0
);

  logic [word_w-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_addr_w; i++)
        regs[i] <= '0;
    end else if (write_en && (write_addr != '0)) begin
      regs[write_addr] <= write_data;  // Register zero never takes a write, so it reads as zero
    end
  end

  // Reads see the old value when the same register is written this cycle
  assign read_data_a = regs[read_addr_a];
  assign read_data_b = regs[read_addr_b];
  assign register_v0 = regs[2];

endmodule

// File: logic/mips_pc_unit.sv
`timescale 1ns/100ps

module mips_pc_unit import mips_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              clk_enable,
  input  logic              branch,
  input  logic              branch_ne,
  input  logic              zero,
  input  logic              jump,
  input  logic              jump_reg,
  input  logic [word_w-1:0] imm,            // Extended immediate, the branch offset in words
  input  logic [25:0]       jump_index,
  input  logic [word_w-1:0] jump_reg_addr,  // rs passed through the ALU
  output logic [word_w-1:0] instr_address,
  output logic [word_w-1:0] link_address,
  output logic              active
);

  logic [word_w-1:0] delay_pc;  // Address of the instruction after the current one
  logic [word_w-1:0] pc_plus4;
  logic [word_w-1:0] branch_target;
  logic [word_w-1:0] jump_target;
  logic [word_w-1:0] next_target;
  logic              taken;

  assign pc_plus4      = instr_address + 32'd4;
  assign link_address  = instr_address + 32'd8;  // Skips over the delay slot
  assign branch_target = pc_plus4 + {imm[word_w-3:0], 2'b00};
  assign jump_target   = jump_reg ? jump_reg_addr : {pc_plus4[31:28], jump_index, 2'b00};

  // beq takes the branch on zero, bne on nonzero
  assign taken = branch & (zero ^ branch_ne);

  always_comb begin
    if (jump)
      next_target = jump_target;
    else if (taken)
      next_target = branch_target;
    else
      next_target = delay_pc + 32'd4;  // Sequential flow continues after the delay slot
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      instr_address <= reset_vector;
      delay_pc      <= reset_vector + 32'd4;
      active        <= 1'b1;
    end else if (clk_enable && active) begin
      instr_address <= delay_pc;  // The slot instruction runs before the target
      delay_pc      <= next_target;
      if (delay_pc == '0)
        active <= 1'b0;  // Drops together with the PC reaching zero, then everything freezes
    end
  end

endmodule

// File: logic/mips_load_select.sv
`timescale 1ns/100ps

module mips_load_select import mips_pkg::*; (
  input  logic [word_w-1:0] read_data,
  input  logic [1:0]        byte_offset,
  input  load_mode_t        load_mode,
  output logic [word_w-1:0] result
);

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  always_comb begin
    // Big-endian, so offset zero is the most significant byte
    case (byte_offset)
      2'd0:    byte_lane = read_data[31:24];
      2'd1:    byte_lane = read_data[23:16];
      2'd2:    byte_lane = read_data[15:8];
      default: byte_lane = read_data[7:0];
    endcase
    half_lane = byte_offset[1] ? read_data[15:0] : read_data[31:16];  // Offset bit 0 ignored
  end

  always_comb begin
    case (load_mode)
      load_byte:   result = {{24{byte_lane[7]}}, byte_lane};
      load_byte_u: result = {24'h000000, byte_lane};
      load_half:   result = {{16{half_lane[15]}}, half_lane};
      load_half_u: result = {16'h0000, half_lane};
      default:     result = read_data;
    endcase
  end

endmodule

// File: logic/mips_control.sv
`timescale 1ns/100ps

module mips_control import mips_pkg::*; (
  input  logic [word_w-1:0] instr_data,
  output logic              reg_write,
  output logic              reg_dst,
  output logic              link,
  output logic              alu_src,
  output logic              imm_zero_ext,
  output logic              mem_to_reg,
  output logic              data_read,
  output logic              data_write,
  output logic              branch,
  output logic              branch_ne,
  output logic              jump,
  output logic              jump_reg,
  output alu_op_t           alu_op,
  output load_mode_t        load_mode
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr_data[31:26];
  assign funct  = instr_data[5:0];  // Only meaningful under op_special

  always_comb begin
    // Everything idle by default, so an unknown word falls through as a no-op
    reg_write    = 1'b0;
    reg_dst      = 1'b0;
    link         = 1'b0;
    alu_src      = 1'b0;
    imm_zero_ext = 1'b0;
    mem_to_reg   = 1'b0;
    data_read    = 1'b0;
    data_write   = 1'b0;
    branch       = 1'b0;
    branch_ne    = 1'b0;
    jump         = 1'b0;
    jump_reg     = 1'b0;
    alu_op       = alu_add;
    load_mode    = load_word;
    case (opcode)
      op_special: begin
        reg_write = 1'b1;  // Most R-type forms write rd
        reg_dst   = 1'b1;
        case (funct)
          fn_sll:  alu_op = alu_sll;
          fn_srl:  alu_op = alu_srl;
          fn_sra:  alu_op = alu_sra;
          fn_sllv: alu_op = alu_sllv;
          fn_srlv: alu_op = alu_srlv;
          fn_srav: alu_op = alu_srav;
          fn_addu: alu_op = alu_add;
          fn_subu: alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          fn_xor:  alu_op = alu_xor;
          fn_nor:  alu_op = alu_nor;
          fn_slt:  alu_op = alu_slt;
          fn_sltu: alu_op = alu_sltu;
          fn_jr: begin
            reg_write = 1'b0;  // rt field is zero, so rs + $0 lands on the ALU output
            jump      = 1'b1;
            jump_reg  = 1'b1;
          end
          fn_jalr: begin
            link     = 1'b1;  // Return address goes to register 31
            jump     = 1'b1;
            jump_reg = 1'b1;
          end
          default: begin
            reg_write = 1'b0;
            reg_dst   = 1'b0;
          end
        endcase
      end
      op_j: jump = 1'b1;
      op_jal: begin
        jump      = 1'b1;
        link      = 1'b1;
        reg_write = 1'b1;
      end
      op_beq, op_bne: begin
        branch    = 1'b1;
        branch_ne = (opcode == op_bne);
        alu_op    = alu_sub;  // Zero flag tells whether rs equals rt
      end
      op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
        reg_write    = 1'b1;
        alu_src      = 1'b1;
        imm_zero_ext = (opcode == op_andi) || (opcode == op_ori) || (opcode == op_xori);
        case (opcode)
          op_slti:  alu_op = alu_slt;
          op_sltiu: alu_op = alu_sltu;
          op_andi:  alu_op = alu_and;
          op_ori:   alu_op = alu_or;
          op_xori:  alu_op = alu_xor;
          op_lui:   alu_op = alu_lui;
          default:  alu_op = alu_add;
        endcase
      end
      op_lw, op_lb, op_lbu, op_lh, op_lhu: begin
        reg_write  = 1'b1;
        alu_src    = 1'b1;  // Base plus signed offset
        mem_to_reg = 1'b1;
        data_read  = 1'b1;
        case (opcode)
          op_lb:   load_mode = load_byte;
          op_lbu:  load_mode = load_byte_u;
          op_lh:   load_mode = load_half;
          op_lhu:  load_mode = load_half_u;
          default: load_mode = load_word;
        endcase
      end
      op_sw: begin
        alu_src    = 1'b1;
        data_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: logic/mips_datapath.sv
`timescale 1ns/100ps

module mips_datapath import mips_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              clk_enable,
  input  logic              reg_write,
  input  logic              reg_dst,
  input  logic              link,
  input  logic              alu_src,
  input  logic              imm_zero_ext,
  input  logic              mem_to_reg,
  input  logic              branch,
  input  logic              branch_ne,
  input  logic              jump,
  input  logic              jump_reg,
  input  alu_op_t           alu_op,
  input  load_mode_t        load_mode,
  input  logic [word_w-1:0] instr_readdata,
  input  logic [word_w-1:0] data_readdata,
  output logic [word_w-1:0] instr_data,
  output logic [word_w-1:0] instr_address,
  output logic [word_w-1:0] data_address,
  output logic [word_w-1:0] data_writedata,
  output logic [word_w-1:0] register_v0,
  output logic              zero,
  output logic              active
);

  logic [word_w-1:0]     imm_ext;
  logic [word_w-1:0]     rs_data;
  logic [word_w-1:0]     rt_data;
  logic [word_w-1:0]     alu_b;
  logic [word_w-1:0]     alu_result;
  logic [word_w-1:0]     load_result;
  logic [word_w-1:0]     link_address;
  logic [word_w-1:0]     write_data;
  logic [reg_addr_w-1:0] write_addr;
  logic                  write_en;

  assign instr_data = instr_readdata;  // Fetched word also feeds the decoder

  // andi, ori and xori take a zero-extended immediate, all others sign-extend
  assign imm_ext = imm_zero_ext ? {16'h0000, instr_data[15:0]}
                                : {{16{instr_data[15]}}, instr_data[15:0]};

  assign alu_b = alu_src ? imm_ext : rt_data;

  always_comb begin
    if (link)
      write_addr = link_reg;
    else if (reg_dst)
      write_addr = instr_data[15:11];  // rd for R-type
    else
      write_addr = instr_data[20:16];  // rt for immediates and loads
  end

  always_comb begin
    if (link)
      write_data = link_address;
    else if (mem_to_reg)
      write_data = load_result;
    else
      write_data = alu_result;
  end

  assign write_en       = reg_write & clk_enable & active;  // No writes while stalled or halted
  assign data_address   = alu_result;
  assign data_writedata = rt_data;

  mips_pc_unit pc_unit (
    .clk           (clk),
    .reset         (reset),
    .clk_enable    (clk_enable),
    .branch        (branch),
    .branch_ne     (branch_ne),
    .zero          (zero),
    .jump          (jump),
    .jump_reg      (jump_reg),
    .imm           (imm_ext),
    .jump_index    (instr_data[25:0]),
    .jump_reg_addr (alu_result),
    .instr_address (instr_address),
    .link_address  (link_address),
    .active        (active)
  );

  mips_regfile regfile (
    .clk         (clk),
    .reset       (reset),
    .write_en    (write_en),
    .read_addr_a (instr_data[25:21]),
    .read_addr_b (instr_data[20:16]),
    .write_addr  (write_addr),
    .write_data  (write_data),
    .read_data_a (rs_data),
    .read_data_b (rt_data),
    .register_v0 (register_v0)
  );

  mips_alu alu (
    .alu_op (alu_op),
    .a      (rs_data),
    .b      (alu_b),
    .shamt  (instr_data[10:6]),
    .result (alu_result),
    .zero   (zero)
  );

  mips_load_select load_select (
    .read_data   (data_readdata),
    .byte_offset (alu_result[1:0]),  // Memory returns the whole aligned word
    .load_mode   (load_mode),
    .result      (load_result)
  );

endmodule

// File: logic/mips_cpu.sv
`timescale 1ns/100ps

module mips_cpu import mips_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              clk_enable,
  input  logic [word_w-1:0] instr_readdata,
  input  logic [word_w-1:0] data_readdata,
  output logic              active,
  output logic [word_w-1:0] instr_address,
  output logic [word_w-1:0] data_address,
  output logic [word_w-1:0] data_writedata,
  output logic              data_write,
  output logic              data_read,
  output logic [word_w-1:0] register_v0
);

  logic [word_w-1:0] instr_data;
  logic              reg_write;
  logic              reg_dst;
  logic              link;
  logic              alu_src;
  logic              imm_zero_ext;
  logic              mem_to_reg;
  logic              dec_data_read;
  logic              dec_data_write;
  logic              branch;
  logic              branch_ne;
  logic              jump;
  logic              jump_reg;
  alu_op_t           alu_op;
  load_mode_t        load_mode;

  // Memory strobes stay low during a stall and after halt
  assign data_write = dec_data_write & clk_enable & active;
  assign data_read  = dec_data_read & clk_enable & active;

  mips_control control (
    .instr_data   (instr_data),
    .reg_write    (reg_write),
    .reg_dst      (reg_dst),
    .link         (link),
    .alu_src      (alu_src),
    .imm_zero_ext (imm_zero_ext),
    .mem_to_reg   (mem_to_reg),
    .data_read    (dec_data_read),
    .data_write   (dec_data_write),
    .branch       (branch),
    .branch_ne    (branch_ne),
    .jump         (jump),
    .jump_reg     (jump_reg),
    .alu_op       (alu_op),
    .load_mode    (load_mode)
  );

  mips_datapath datapath (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .reg_write      (reg_write),
    .reg_dst        (reg_dst),
    .link           (link),
    .alu_src        (alu_src),
    .imm_zero_ext   (imm_zero_ext),
    .mem_to_reg     (mem_to_reg),
    .branch         (branch),
    .branch_ne      (branch_ne),
    .jump           (jump),
    .jump_reg       (jump_reg),
    .alu_op         (alu_op),
    .load_mode      (load_mode),
    .instr_readdata (instr_readdata),
    .data_readdata  (data_readdata),
    .instr_data     (instr_data),
    .instr_address  (instr_address),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .register_v0    (register_v0),
    .zero           (),  // Branch decision is taken inside the PC unit
    .active         (active)
  );

endmodule

// File: tests/mips_cpu_checker.sv
`timescale 1ns/100ps

module mips_cpu_checker import mips_pkg::*; (
  input logic              clk,
  input logic              reset,
  input logic              active,
  input logic              data_write,
  input logic [word_w-1:0] instr_address
);

  // A halted core issues no stores
  store_while_halted: assert property (
    @(posedge clk) disable iff (reset) !active |-> !data_write
  ) else $error("data_write high while active is low");

  // Only reset brings a halted core back
  halt_is_final: assert property (
    @(posedge clk) disable iff (reset) !active |=> !active
  ) else $error("active rose again without reset");

  fetch_aligned: assert property (
    @(posedge clk) disable iff (reset) instr_address[1:0] == 2'b00  // Fetches stay on words
  ) else $error("instr_address %h is not word aligned", instr_address);

endmodule

// File: tests/mips_cpu_tb.sv
`timescale 1ns/100ps

module mips_cpu_tb import mips_pkg::*; ();

  localparam int clk_period = 40;
  localparam int num_tests  = 8;

  logic              clk;
  logic              reset;
  logic              clk_enable;
  logic [word_w-1:0] instr_readdata;
  logic [word_w-1:0] data_readdata;
  logic              active;
  logic [word_w-1:0] instr_address;
  logic [word_w-1:0] data_address;
  logic [word_w-1:0] data_writedata;
  logic              data_write;
  logic              data_read;
  logic [word_w-1:0] register_v0;

  logic [word_w-1:0] imem [256];   // Program, word 0 sits at reset_vector
  logic [word_w-1:0] dmem [64];    // Memory seen by the DUT
  logic [word_w-1:0] mdmem [64];   // Model copy of the same memory
  logic [word_w-1:0] mregs [32];
  logic [word_w-1:0] model_pc;
  logic [word_w-1:0] model_npc;    // Address that runs after model_pc
  logic              model_active;
  int                seed;
  int                errors;
  int                checks;
  int                retired;

  mips_cpu dut (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .instr_readdata (instr_readdata),
    .data_readdata  (data_readdata),
    .active         (active),
    .instr_address  (instr_address),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_read      (data_read),
    .register_v0    (register_v0)
  );

  bind mips_cpu mips_cpu_checker bus_checks (
    .clk           (clk),
    .reset         (reset),
    .active        (active),
    .data_write    (data_write),
    .instr_address (instr_address)
  );

  assign instr_readdata = imem[instr_address[9:2]];  // Both memories answer in the same cycle
  assign data_readdata  = dmem[data_address[7:2]];

  always @(posedge clk) begin
    if (data_write)
      dmem[data_address[7:2]] <= data_writedata;
  end

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  function automatic int unsigned rnd(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] enc_r(int rs, int rt, int rd, int sh, logic [5:0] fn);
    return {op_special, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic logic [31:0] enc_i(logic [5:0] op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  // Sources come from registers 0 to 7, results land in 1 to 7
  function automatic logic [31:0] random_alu();
    logic [5:0] r_fns [14];
    logic [5:0] i_ops [7];
    r_fns = '{fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav, fn_addu,
              fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
    i_ops = '{op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui};
    if (rnd(2) == 0)
      return enc_r(rnd(8), rnd(8), rnd(7) + 1, rnd(32), r_fns[rnd(14)]);
    return enc_i(i_ops[rnd(7)], rnd(8), rnd(7) + 1, rnd(65536));
  endfunction

  // Base register is $0, so the offset is the whole address inside data memory
  function automatic logic [31:0] random_load();
    logic [5:0] ops [5];
    int         sel;
    int         offset;
    int         dest;
    ops = '{op_lw, op_lb, op_lbu, op_lh, op_lhu};
    sel = rnd(5);
    offset = rnd(64) * 4;
    if (sel == 1 || sel == 2)
      offset += rnd(4);      // Any byte lane
    else if (sel >= 3)
      offset += rnd(2) * 2;  // Either half word
    dest = (rnd(2) == 0) ? 2 : rnd(7) + 1;  // Favour v0 so loaded values show up
    return enc_i(ops[sel], 0, dest, offset);
  endfunction

  function automatic logic [31:0] random_plain();
    case (rnd(4))
      0, 1:    return random_alu();
      2:       return random_load();
      default: return enc_i(op_sw, 0, rnd(8), rnd(64) * 4);
    endcase
  endfunction

  task automatic build_program(input int len);
    int pos;
    int kind;
    int skip;
    for (int i = 0; i < 256; i++)
      imem[i] = '0;
    imem[0] = random_alu();  // No store in the first cycle after reset
    pos = 1;
    while (pos < len - 9) begin
      kind = rnd(10);
      if (kind == 7 || kind == 8) begin
        skip = rnd(5);  // Target lies past the slot and up to four more words
        if (kind == 7)
          imem[pos] = enc_i((rnd(2) == 0) ? op_beq : op_bne, rnd(8), rnd(8), skip + 1);
        else
          imem[pos] = {op_jal, 26'((reset_vector + 4 * (pos + 2 + skip)) >> 2)};
        imem[pos + 1] = random_plain();  // Delay slot
        for (int k = 0; k < skip; k++)
          imem[pos + 2 + k] = random_alu();
        pos = pos + 2 + skip;
        if (kind == 8) begin
          imem[pos] = enc_r(31, 0, 2, 0, fn_addu);  // Copy the link into v0
          pos++;
        end
      end else if (kind == 4 || kind == 5) begin
        imem[pos] = random_load();
        pos++;
      end else begin
        imem[pos] = (kind == 6) ? enc_i(op_sw, 0, rnd(8), rnd(64) * 4) : random_alu();
        pos++;
      end
    end
    imem[len - 2] = enc_r(0, 0, 0, 0, fn_jr);  // Jump to zero ends the run
    imem[len - 1] = '0;
  endtask

  // One instruction of the architecture, with the delayed PC pair
  task automatic model_step();
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] zimm;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] wd;
    logic [31:0] next;
    logic [7:0]  lane8;
    logic [15:0] lane16;
    logic [4:0]  waddr;
    logic        wr;
    instr = imem[model_pc[9:2]];
    a = mregs[instr[25:21]];
    b = mregs[instr[20:16]];
    simm = {{16{instr[15]}}, instr[15:0]};
    zimm = {16'h0000, instr[15:0]};
    addr = a + simm;
    word = mdmem[addr[7:2]];
    lane8 = 8'(word >> (24 - 8 * addr[1:0]));    // Byte 0 is the top lane
    lane16 = 16'(word >> (16 - 16 * addr[1]));
    next = model_npc + 4;
    wr = 1'b1;
    waddr = instr[20:16];
    wd = '0;
    case (instr[31:26])
      op_special: begin
        waddr = instr[15:11];
        case (instr[5:0])
          fn_sll:  wd = b << instr[10:6];
          fn_srl:  wd = b >> instr[10:6];
          fn_sra:  wd = $signed(b) >>> instr[10:6];
          fn_sllv: wd = b << a[4:0];
          fn_srlv: wd = b >> a[4:0];
          fn_srav: wd = $signed(b) >>> a[4:0];
          fn_addu: wd = a + b;
          fn_subu: wd = a - b;
          fn_and:  wd = a & b;
          fn_or:   wd = a | b;
          fn_xor:  wd = a ^ b;
          fn_nor:  wd = ~(a | b);
          fn_slt:  wd = {31'b0, $signed(a) < $signed(b)};
          fn_sltu: wd = {31'b0, a < b};
          fn_jr: begin
            next = a;
            wr = 1'b0;
          end
          fn_jalr: begin
            next = a;
            waddr = link_reg;
            wd = model_pc + 8;
          end
          default: wr = 1'b0;
        endcase
      end
      op_j, op_jal: begin
        next = {model_pc[31:28] + 4'(model_pc[27:0] >= 28'hFFFFFFC), instr[25:0], 2'b00};
        wr = (instr[31:26] == op_jal);
        waddr = link_reg;
        wd = model_pc + 8;  // Return lands after the delay slot
      end
      op_beq, op_bne: begin
        wr = 1'b0;
        if ((a == b) == (instr[31:26] == op_beq))
          next = model_pc + 4 + (simm << 2);
      end
      op_addiu: wd = a + simm;
      op_slti:  wd = {31'b0, $signed(a) < $signed(simm)};
      op_sltiu: wd = {31'b0, a < simm};
      op_andi:  wd = a & zimm;
      op_ori:   wd = a | zimm;
      op_xori:  wd = a ^ zimm;
      op_lui:   wd = {instr[15:0], 16'h0000};
      op_lw:    wd = word;
      op_lb:    wd = {{24{lane8[7]}}, lane8};
      op_lbu:   wd = {24'h000000, lane8};
      op_lh:    wd = {{16{lane16[15]}}, lane16};
      op_lhu:   wd = {16'h0000, lane16};
      op_sw: begin
        wr = 1'b0;
        mdmem[addr[7:2]] = b;
      end
      default: wr = 1'b0;
    endcase
    if (wr && waddr != 5'd0)
      mregs[waddr] = wd;
    model_pc = model_npc;
    model_npc = next;
    if (model_pc == '0)
      model_active = 1'b0;  // Fetch of address zero halts the core
    retired++;
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH time %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // Called at the falling edge, where every DUT output has settled
  task automatic check_outputs();
    logic [31:0] instr;
    logic [5:0]  op;
    logic        live;
    logic        is_store;
    logic        is_load;
    instr = imem[model_pc[9:2]];
    op = instr[31:26];
    live = model_active && clk_enable;
    is_store = live && (op == op_sw);
    is_load = live && (op == op_lw || op == op_lb || op == op_lbu || op == op_lh
                       || op == op_lhu);
    check_value("instr_address", model_pc, instr_address);
    check_value("active", model_active, active);
    check_value("data_write", is_store, data_write);
    check_value("data_read", is_load, data_read);
    check_value("register_v0", mregs[2], register_v0);
    if (is_store) begin
      check_value("data_address", mregs[instr[25:21]] + {{16{instr[15]}}, instr[15:0]},
                  data_address);
      check_value("data_writedata", mregs[instr[20:16]], data_writedata);
    end
  endtask

  task automatic run_test(input int t);
    int len;
    int cycles;
    int err_start;
    len = 64 + 16 * t;
    err_start = errors;
    retired = 0;
    cycles = 0;
    build_program(len);
    for (int i = 0; i < 64; i++) begin
      dmem[i] = $random(seed);
      mdmem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++)
      mregs[i] = '0;
    model_pc = reset_vector;
    model_npc = reset_vector + 4;
    model_active = 1'b1;
    @(posedge clk);
    reset <= 1'b1;
    clk_enable <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (instr_address !== reset_vector || active !== 1'b1 || data_write !== 1'b0) begin
      errors++;
      $display("Test %0d: core not at the reset vector with active high after reset", t);
    end
    forever begin
      check_outputs();
      if (clk_enable && model_active)
        model_step();
      if (active !== 1'b1)
        break;  // Halted, the model has been compared on the same edge
      @(posedge clk);
      clk_enable <= (rnd(4) != 0);  // Roughly one stall cycle in four
      cycles++;
      @(negedge clk);
    end
    repeat (3) begin
      @(posedge clk);
      clk_enable <= (rnd(4) != 0);
      @(negedge clk);
      check_outputs();  // PC must stay at zero with no stores
    end
    for (int i = 0; i < 64; i++)
      check_value($sformatf("dmem[%0d]", i), mdmem[i], dmem[i]);
    $display("Test %0d: %0d words, %0d retired, %0d cycles, %0d errors", t, len, retired,
             cycles, errors - err_start);
  endtask

  initial begin : watchdog
    longint limit;
    limit = 0;
    for (int t = 0; t < num_tests; t++)
      limit += (64 + 16 * t) * 4 + 20;
    #(limit * clk_period);
    $display("Timeout after %0d clock periods, active never dropped", limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    seed = 78222;
    errors = 0;
    checks = 0;
    retired = 0;
    reset = 1'b1;
    clk_enable = 1'b0;
    for (int i = 0; i < 256; i++)
      imem[i] = '0;
    for (int i = 0; i < 64; i++)
      dmem[i] = '0;
    for (int t = 0; t < num_tests; t++)
      run_test(t);
    $display("Tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: files.f
logic/mips_pkg.sv
logic/mips_alu.sv
logic/mips_regfile.sv
logic/mips_pc_unit.sv
logic/mips_load_select.sv
logic/mips_control.sv
logic/mips_datapath.sv
logic/mips_cpu.sv
tests/mips_cpu_checker.sv
tests/mips_cpu_tb.sv

// File: Bender.yml
package:
  name: mips_cpu

sources:
  - logic/mips_pkg.sv
  - logic/mips_alu.sv
  - logic/mips_regfile.sv
  - logic/mips_pc_unit.sv
  - logic/mips_load_select.sv
  - logic/mips_control.sv
  - logic/mips_datapath.sv
  - logic/mips_cpu.sv
  - target: test
    files:
      - tests/mips_cpu_checker.sv
      - tests/mips_cpu_tb.sv
